/* logic/dma_pkg.sv */
/* DMA initiator shared definitions
 * Field widths, header flit layout, Wishbone cycle types and FSM encodings
 */
`default_nettype none

package dma_pkg;

  //////////////////////////////
  // Descriptor field widths
  //////////////////////////////

  // Word count of one transfer
  localparam int DMA_SIZE_WIDTH = 10;
  // NoC destination tile
  localparam int DMA_DEST_WIDTH = 5;

  // Request opcodes, only L2R is executed by this initiator
  typedef enum logic [1:0] {
    DMA_OP_L2R = 2'b00,
    DMA_OP_R2L = 2'b01,
    DMA_OP_NOP = 2'b11
  } dma_op_e;

  //////////////////////////////
  // Wishbone cycle types
  //////////////////////////////

  // Incrementing burst and end of burst
  localparam logic [2:0] WB_CTI_INCR = 3'b010;
  localparam logic [2:0] WB_CTI_END  = 3'b111;

  //////////////////////////////
  // Header flit layout
  //////////////////////////////

  // Destination in the top bits, word count at the bottom
  localparam int HDR_DEST_LSB = 27;
  localparam int HDR_SIZE_LSB = 0;

  //////////////////////////////
  // FSM encodings
  //////////////////////////////

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_DATA, FETCH_WAIT} wb_fetch_state_e;
  typedef enum logic [1:0] {PKT_IDLE, PKT_HEADER, PKT_PAYLOAD} pkt_state_e;
  typedef enum logic {REQ_IDLE, REQ_BUSY} req_state_e;

endpackage

`default_nettype wire

/* logic/dma_req_decoder.sv */
/* DMA request decoder
 * Checks a request descriptor, latches it and tracks the single transfer in flight
 */
`timescale 1ns/1ns
`default_nettype none

module dma_req_decoder
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  // Descriptor strobe from software
  input  wire                      req_valid_i,
  input  dma_op_e                  req_op_i,
  input  wire [ADDR_WIDTH-1:0]     req_laddr_i,
  input  wire [DMA_SIZE_WIDTH-1:0] req_size_i,
  input  wire [DMA_DEST_WIDTH-1:0] req_dest_i,
  // Completion from the packetizer
  input  wire                      done_i,
  // Held descriptor towards the datapath
  output logic                     start_o,
  output logic [ADDR_WIDTH-1:0]    laddr_o,
  output logic [DMA_SIZE_WIDTH-1:0] size_o,
  output logic [DMA_DEST_WIDTH-1:0] dest_o,
  output logic                     busy_o,
  output logic                     err_o
);

  req_state_e state;

  logic op_ok;
  logic size_ok;
  logic accept;

  //////////////////////////////
  // Descriptor check
  //////////////////////////////

  // Only local-to-remote transfers are executed
  assign op_ok   = (req_op_i == DMA_OP_L2R);
  // Zero-length transfers are refused
  assign size_ok = |req_size_i;
  // One request at a time, strobes while busy are refused
  assign accept  = req_valid_i & (state == REQ_IDLE) & op_ok & size_ok;

  assign busy_o = (state == REQ_BUSY);

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= REQ_IDLE;
      start_o <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      // Start and error pulse one cycle after the strobe
      start_o <= accept;
      err_o   <= req_valid_i & ~accept;
      case (state)
        REQ_IDLE: begin
          if (accept) begin
            state <= REQ_BUSY;
          end
        end
        REQ_BUSY: begin
          // Busy drops the cycle after the last flit completes
          if (done_i) begin
            state <= REQ_IDLE;
          end
        end
        default: state <= REQ_IDLE;
      endcase
    end
  end

  // Descriptor hold registers, stable for the whole transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      laddr_o <= req_laddr_i;
      size_o  <= req_size_i;
      dest_o  <= req_dest_i;
    end
  end

endmodule

`default_nettype wire

/* logic/dma_wb_fetch.sv */
/* Wishbone burst fetch for L2R transfers
 * Reads local words in incrementing bursts into a three-entry decoupling FIFO
 */
`timescale 1ns/1ns
`default_nettype none

module dma_wb_fetch
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  // Held descriptor
  input  wire                      start_i,
  input  wire [ADDR_WIDTH-1:0]     laddr_i,
  input  wire [DMA_SIZE_WIDTH-1:0] size_i,
  // Wishbone master
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [ADDR_WIDTH-1:0]    wb_adr_o,
  output logic [DATA_WIDTH-1:0]    wb_dat_o,
  input  wire  [DATA_WIDTH-1:0]    wb_dat_i,
  output logic [DATA_WIDTH/8-1:0]  wb_sel_o,
  output logic [2:0]               wb_cti_o,
  output logic [1:0]               wb_bte_o,
  input  wire                      wb_ack_i,
  // Word stream to the packetizer
  output logic                     data_valid_o,
  output logic [DATA_WIDTH-1:0]    data_o,
  input  wire                      data_ready_i
);

  wb_fetch_state_e state;
  wb_fetch_state_e state_nxt;

  // Words read so far in this transfer
  logic [DMA_SIZE_WIDTH-1:0] count;
  logic [DMA_SIZE_WIDTH-1:0] count_nxt;
  logic [ADDR_WIDTH-1:0]     byte_offset;
  logic                      last_word;

  //////////////////////////////
  // Decoupling FIFO
  //////////////////////////////

  // Three entries cover normal decoupling, the cycle the bus needs to see
  // back-pressure and the burst termination beat
  logic [DATA_WIDTH-1:0] fifo_mem [3];
  // One-hot fill level where bit k set means k entries held
  logic [3:0]            fifo_pos;
  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  fifo_empty;
  // Below the high-water mark of two words and decoded from registers only
  logic                  fifo_room;

  assign fifo_empty = fifo_pos[0];
  assign fifo_room  = ~|fifo_pos[3:2];
  // Never pop an empty FIFO
  assign fifo_pop   = data_ready_i & ~fifo_empty;

  assign data_valid_o = ~fifo_empty;
  assign data_o       = fifo_mem[0];

  // Fill level moves only on a lone push or a lone pop
  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_pos <= 4'b0001;
    end else if (fifo_push & ~fifo_pop) begin
      fifo_pos <= fifo_pos << 1;
    end else if (fifo_pop & ~fifo_push) begin
      fifo_pos <= fifo_pos >> 1;
    end
  end

  // Head is entry 0 and a pop shifts everything down by one
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (fifo_pop) begin
        // Push lands one slot lower when popping at the same time
        if (fifo_push & fifo_pos[i+1]) begin
          fifo_mem[i] <= wb_dat_i;
        end else begin
          fifo_mem[i] <= fifo_mem[i+1];
        end
      end else if (fifo_push & fifo_pos[i]) begin
        fifo_mem[i] <= wb_dat_i;
      end
    end
    // Last entry has nothing above it to shift in
    if (fifo_push & ((fifo_pop & fifo_pos[3]) | (~fifo_pop & fifo_pos[2]))) begin
      fifo_mem[2] <= wb_dat_i;
    end
  end

  //////////////////////////////
  // Wishbone side
  //////////////////////////////

  // Read-only master with full aligned words and linear bursts
  assign wb_we_o  = 1'b0;
  assign wb_dat_o = '0;
  assign wb_sel_o = '1;
  assign wb_bte_o = 2'b00;

  // Word counter to byte address
  assign byte_offset = ADDR_WIDTH'(count) << 2;
  assign wb_adr_o    = laddr_i + byte_offset;

  assign last_word = (count == size_i - DMA_SIZE_WIDTH'(1));

  // Bus is active only while fetching and inserts no wait states
  assign wb_cyc_o = (state == FETCH_DATA);
  assign wb_stb_o = wb_cyc_o;

  // Terminate the burst on the last word or when the FIFO nears full
  assign wb_cti_o = (last_word | ~fifo_room) ? WB_CTI_END : WB_CTI_INCR;

  // Next state and word counting
  always_comb begin
    state_nxt = state;
    count_nxt = count;
    fifo_push = 1'b0;
    case (state)
      FETCH_IDLE: begin
        count_nxt = '0;
        // FIFO is always empty here so go straight to the bus
        if (start_i) begin
          state_nxt = FETCH_DATA;
        end
      end
      FETCH_DATA: begin
        if (wb_ack_i) begin
          fifo_push = 1'b1;
          count_nxt = count + DMA_SIZE_WIDTH'(1);
          if (last_word) begin
            state_nxt = FETCH_IDLE;
          end else if (!fifo_room) begin
            // END was signalled on this beat so cyc drops
            state_nxt = FETCH_WAIT;
          end
        end
      end
      FETCH_WAIT: begin
        // Restart the burst once the FIFO drained below two words
        if (fifo_room) begin
          state_nxt = FETCH_DATA;
        end
      end
      default: state_nxt = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH_IDLE;
      count <= '0;
    end else begin
      state <= state_nxt;
      count <= count_nxt;
    end
  end

endmodule

`default_nettype wire

/* logic/dma_noc_packetizer.sv */
/* NoC packetizer for L2R transfers
 * Sends a header flit then one payload flit per word and flags completion
 */
`timescale 1ns/1ns
`default_nettype none

module dma_noc_packetizer
  import dma_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  // Held descriptor
  input  wire                      start_i,
  input  wire [DMA_DEST_WIDTH-1:0] dest_i,
  input  wire [DMA_SIZE_WIDTH-1:0] size_i,
  // Word stream from the fetch block
  input  wire                      data_valid_i,
  input  wire [DATA_WIDTH-1:0]     data_i,
  output logic                     data_ready_o,
  // NoC link
  output logic [DATA_WIDTH-1:0]    noc_flit_o,
  output logic                     noc_last_o,
  output logic                     noc_valid_o,
  input  wire                      noc_ready_i,
  // Completion pulse
  output logic                     done_o
);

  pkt_state_e state;

  // Payload words sent so far
  logic [DMA_SIZE_WIDTH-1:0] count;
  logic                      last_word;
  logic                      payload_xfer;
  logic [DATA_WIDTH-1:0]     header_flit;

  //////////////////////////////
  // Flit assembly
  //////////////////////////////

  // Header carries destination and word count
  always_comb begin
    header_flit = '0;
    header_flit[HDR_DEST_LSB +: DMA_DEST_WIDTH] = dest_i;
    header_flit[HDR_SIZE_LSB +: DMA_SIZE_WIDTH] = size_i;
  end

  assign last_word = (count == size_i - DMA_SIZE_WIDTH'(1));

  // FIFO head is stable until popped so a stalled flit holds
  assign noc_flit_o  = (state == PKT_HEADER) ? header_flit : data_i;
  assign noc_valid_o = (state == PKT_HEADER) | ((state == PKT_PAYLOAD) & data_valid_i);
  assign noc_last_o  = (state == PKT_PAYLOAD) & last_word;

  // Pop a word only when the NoC takes it
  assign data_ready_o = (state == PKT_PAYLOAD) & noc_ready_i;
  assign payload_xfer = data_ready_o & data_valid_i;

  //////////////////////////////
  // Packet FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= PKT_IDLE;
      count  <= '0;
      done_o <= 1'b0;
    end else begin
      // Done follows the handshake of the final flit
      done_o <= payload_xfer & last_word;
      case (state)
        PKT_IDLE: begin
          if (start_i) begin
            state <= PKT_HEADER;
            count <= '0;
          end
        end
        PKT_HEADER: begin
          if (noc_ready_i) begin
            state <= PKT_PAYLOAD;
          end
        end
        PKT_PAYLOAD: begin
          if (payload_xfer) begin
            count <= count + DMA_SIZE_WIDTH'(1);
            if (last_word) begin
              state <= PKT_IDLE;
            end
          end
        end
        default: state <= PKT_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/dma_initiator_top.sv */
/* DMA initiator read side
 * Request decoder, Wishbone fetch and NoC packetizer for L2R transfers
 */
`timescale 1ns/1ns
`default_nettype none

module dma_initiator_top
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  // Request descriptor
  input  wire                      req_valid_i,
  input  dma_op_e                  req_op_i,
  input  wire [ADDR_WIDTH-1:0]     req_laddr_i,
  input  wire [DMA_SIZE_WIDTH-1:0] req_size_i,
  input  wire [DMA_DEST_WIDTH-1:0] req_dest_i,
  output logic                     busy_o,
  output logic                     err_o,
  output logic                     done_o,
  // Wishbone master
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [ADDR_WIDTH-1:0]    wb_adr_o,
  output logic [DATA_WIDTH-1:0]    wb_dat_o,
  input  wire  [DATA_WIDTH-1:0]    wb_dat_i,
  output logic [DATA_WIDTH/8-1:0]  wb_sel_o,
  output logic [2:0]               wb_cti_o,
  output logic [1:0]               wb_bte_o,
  input  wire                      wb_ack_i,
  // NoC link
  output logic [DATA_WIDTH-1:0]    noc_flit_o,
  output logic                     noc_last_o,
  output logic                     noc_valid_o,
  input  wire                      noc_ready_i
);

  // Held descriptor
  logic                      start;
  logic [ADDR_WIDTH-1:0]     laddr;
  logic [DMA_SIZE_WIDTH-1:0] size;
  logic [DMA_DEST_WIDTH-1:0] dest;

  // Word stream between fetch and packetizer
  logic                      data_valid;
  logic [DATA_WIDTH-1:0]     data;
  logic                      data_ready;

  dma_req_decoder #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_req_decoder (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_laddr_i (req_laddr_i),
    .req_size_i  (req_size_i),
    .req_dest_i  (req_dest_i),
    // Completion pulse is also the external done
    .done_i      (done_o),
    .start_o     (start),
    .laddr_o     (laddr),
    .size_o      (size),
    .dest_o      (dest),
    .busy_o      (busy_o),
    .err_o       (err_o)
  );

  dma_wb_fetch #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_wb_fetch (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .laddr_i      (laddr),
    .size_i       (size),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_o     (wb_sel_o),
    .wb_cti_o     (wb_cti_o),
    .wb_bte_o     (wb_bte_o),
    .wb_ack_i     (wb_ack_i),
    .data_valid_o (data_valid),
    .data_o       (data),
    .data_ready_i (data_ready)
  );

  dma_noc_packetizer #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_noc_packetizer (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .dest_i       (dest),
    .size_i       (size),
    .data_valid_i (data_valid),
    .data_i       (data),
    .data_ready_o (data_ready),
    .noc_flit_o   (noc_flit_o),
    .noc_last_o   (noc_last_o),
    .noc_valid_o  (noc_valid_o),
    .noc_ready_i  (noc_ready_i),
    .done_o       (done_o)
  );

endmodule

`default_nettype wire

/* tests/wb_mem_model.sv */
/* Wishbone memory model
 * Read-only slave with random wait states and data derived from the address
 */
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model #(
  parameter int          ADDR_WIDTH = 32,
  parameter int          DATA_WIDTH = 32,
  parameter logic [31:0] SEED       = 32'haa5ea1c4
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   cyc_i,
  input  wire                   stb_i,
  input  wire  [ADDR_WIDTH-1:0] adr_i,
  output logic [DATA_WIDTH-1:0] dat_o,
  output logic                  ack_o
);

  // Read data is the byte address of the word with this pattern folded in
  localparam logic [31:0] PATTERN = 32'h5a5a0000;

  int          seed;
  // Wait cycles left before the current beat is acked
  logic [1:0]  delay;
  logic [31:0] rnd;

  initial begin
    seed = SEED;
  end

  // Zero delay acks in the same cycle as stb
  assign ack_o = cyc_i & stb_i & (delay == 2'd0);
  assign dat_o = ack_o ? (DATA_WIDTH'(adr_i) ^ DATA_WIDTH'(PATTERN)) : '0;

  //////////////////////////////
  // Wait state counter
  //////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      delay <= 2'd0;
    end else if (cyc_i & stb_i) begin
      if (ack_o) begin
        // New delay of 0 to 3 cycles for the next beat
        rnd = $random(seed);
        delay <= rnd[1:0];
      end else begin
        delay <= delay - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/dma_initiator_asserts.sv */
/* Protocol checks for the DMA initiator
 * Wishbone master rules, NoC hold under back-pressure and decoder pulses
 */
`timescale 1ns/1ns
`default_nettype none

module dma_initiator_asserts
  import dma_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input wire                  clk,
  input wire                  rst,
  input wire                  cyc_i,
  input wire                  stb_i,
  input wire                  we_i,
  input wire                  ack_i,
  input wire [2:0]            cti_i,
  input wire                  busy_i,
  input wire                  err_i,
  input wire                  start_i,
  input wire [DATA_WIDTH-1:0] flit_i,
  input wire                  last_i,
  input wire                  valid_i,
  input wire                  ready_i
);

  //////////////////////////////
  // Wishbone master
  //////////////////////////////

  a_stb_cyc: assert property (@(posedge clk) disable iff (rst) stb_i == cyc_i)
    else $error("wb_stb_o differs from wb_cyc_o");

  // Read-only master
  a_no_write: assert property (@(posedge clk) disable iff (rst) cyc_i |-> !we_i)
    else $error("wb_we_o high during a bus cycle");

  a_idle_bus: assert property (@(posedge clk) disable iff (rst) !busy_i |-> !cyc_i)
    else $error("wb_cyc_o high while the initiator is idle");

  // Every burst closes on an acked END beat
  a_burst_end: assert property (@(posedge clk) disable iff (rst)
    $fell(cyc_i) |-> ($past(ack_i) && $past(cti_i) == WB_CTI_END))
    else $error("burst ended without an acked END cycle type");

  //////////////////////////////
  // NoC and decoder
  //////////////////////////////

  // Stalled flit stays frozen
  a_flit_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> (valid_i && $stable(flit_i) && $stable(last_i)))
    else $error("NoC flit changed while stalled");

  a_err_start: assert property (@(posedge clk) disable iff (rst) !(err_i && start_i))
    else $error("err_o and start high together");

endmodule

bind dma_initiator_top dma_initiator_asserts #(
  .DATA_WIDTH (DATA_WIDTH)
) i_asserts (
  .clk     (clk),
  .rst     (rst),
  .cyc_i   (wb_cyc_o),
  .stb_i   (wb_stb_o),
  .we_i    (wb_we_o),
  .ack_i   (wb_ack_i),
  .cti_i   (wb_cti_o),
  .busy_i  (busy_o),
  .err_i   (err_o),
  .start_i (start),
  .flit_i  (noc_flit_o),
  .last_i  (noc_last_o),
  .valid_i (noc_valid_o),
  .ready_i (noc_ready_i)
);

`default_nettype wire

/* tests/tb_dma_initiator.sv */
/* DMA initiator testbench
 * L2R transfers of several sizes under back-pressure, plus refused requests
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_initiator
  import dma_pkg::*;
();

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int TIMEOUT    = 5000;

  logic clk;
  logic rst;
  logic req_valid;
  dma_op_e req_op;
  logic [ADDR_WIDTH-1:0] req_laddr;
  logic [DMA_SIZE_WIDTH-1:0] req_size;
  logic [DMA_DEST_WIDTH-1:0] req_dest;
  logic ready;
  logic busy;
  logic err;
  logic done;
  logic cyc;
  logic stb;
  logic we;
  logic ack;
  logic [ADDR_WIDTH-1:0] adr;
  logic [DATA_WIDTH-1:0] dat_w;
  logic [DATA_WIDTH-1:0] dat_r;
  logic [DATA_WIDTH/8-1:0] sel;
  logic [2:0] cti;
  logic [1:0] bte;
  logic [DATA_WIDTH-1:0] flit;
  logic last;
  logic valid;

  int seed = 32'haa5ea1c4;
  // Expected flits in order with the header first
  logic [DATA_WIDTH-1:0] exp_flit [$];
  logic exp_last [$];
  int errors;
  int err_seen;
  int err_expected;
  int done_seen;
  int accepted;
  bit in_flight;
  bit ready_random;

  dma_initiator_top #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) i_dut (
    .clk (clk), .rst (rst),
    .req_valid_i (req_valid), .req_op_i (req_op), .req_laddr_i (req_laddr),
    .req_size_i (req_size), .req_dest_i (req_dest),
    .busy_o (busy), .err_o (err), .done_o (done),
    .wb_cyc_o (cyc), .wb_stb_o (stb), .wb_we_o (we), .wb_adr_o (adr),
    .wb_dat_o (dat_w), .wb_dat_i (dat_r), .wb_sel_o (sel), .wb_cti_o (cti),
    .wb_bte_o (bte), .wb_ack_i (ack),
    .noc_flit_o (flit), .noc_last_o (last), .noc_valid_o (valid), .noc_ready_i (ready)
  );

  wb_mem_model #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) i_mem (
    .clk (clk), .rst (rst), .cyc_i (cyc), .stb_i (stb), .adr_i (adr),
    .dat_o (dat_r), .ack_o (ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // NoC sink ready is about 70% high when randomized
  initial begin
    logic [31:0] rnd;
    ready = 1'b1;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      ready = ready_random ? (rnd[3:0] < 4'd11) : 1'b1;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  // Each NoC handshake is compared with the head of the model queue
  always @(posedge clk) begin
    if (!rst) begin
      if (valid && ready) begin
        assert (exp_flit.size() != 0) else begin
          errors++;
          $display("Flit %h at %0t arrived with no flit expected", flit, $time);
        end
        if (exp_flit.size() != 0) begin
          check_value("noc_flit_o", flit, exp_flit.pop_front());
          check_value("noc_last_o", 32'(last), 32'(exp_last.pop_front()));
        end
      end
      // Each bus beat moves a full word in a linear burst
      if (cyc && ack) begin
        check_value("wb_sel_o", 32'(sel), 32'({(DATA_WIDTH/8){1'b1}}));
        check_value("wb_bte_o", 32'(bte), 32'd0);
      end
      if (err) err_seen++;
      if (done) done_seen++;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One strobe with the expected flits queued if it should be taken
  task automatic send_request(input dma_op_e op, input logic [31:0] laddr,
                              input logic [9:0] size, input logic [4:0] dest);
    logic take;
    logic [DATA_WIDTH-1:0] hdr;
    take = (op == DMA_OP_L2R) && (size != 10'd0) && !in_flight;
    if (take) begin
      hdr = '0;
      hdr[HDR_DEST_LSB +: DMA_DEST_WIDTH] = dest;
      hdr[HDR_SIZE_LSB +: DMA_SIZE_WIDTH] = size;
      exp_flit.push_back(hdr);
      exp_last.push_back(1'b0);
      for (int k = 0; k < int'(size); k++) begin
        exp_flit.push_back((laddr + 32'(4 * k)) ^ 32'h5a5a0000);
        exp_last.push_back(k == int'(size) - 1);
      end
      in_flight = 1'b1;
      accepted++;
    end else begin
      err_expected++;
    end
    req_valid = 1'b1;
    req_op    = op;
    req_laddr = laddr;
    req_size  = size;
    req_dest  = dest;
    @(negedge clk);
    req_valid = 1'b0;
    // Response to the strobe is visible one cycle later
    check_value("err_o", 32'(err), 32'(!take));
    if (take) check_value("busy_o", 32'(busy), 32'd1);
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      errors++;
      $display("Timeout after %0d cycles waiting for done_o", TIMEOUT);
    end else begin
      in_flight = 1'b0;
      assert (exp_flit.size() == 0) else begin
        errors++;
        $display("Transfer completed with %0d flits never sent", exp_flit.size());
      end
      @(negedge clk);
      check_value("done_o", 32'(done), 32'd0);
      check_value("busy_o", 32'(busy), 32'd0);
    end
  endtask

  // Refused strobe while idle leaves bus and NoC quiet
  task automatic refuse_idle(input dma_op_e op, input logic [9:0] size);
    send_request(op, 32'h0000_4000, size, 5'd7);
    repeat (8) begin
      @(negedge clk);
      check_value("wb_cyc_o", 32'(cyc), 32'd0);
      check_value("busy_o", 32'(busy), 32'd0);
    end
  endtask

  task automatic finish_run();
    check_value("err_o pulses", err_seen, err_expected);
    check_value("done_o pulses", done_seen, accepted);
    $display("Errors %0d, err_o pulses %0d of %0d, done_o pulses %0d of %0d",
             errors, err_seen, err_expected, done_seen, accepted);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin
    errors = 0;
    err_seen = 0;
    err_expected = 0;
    done_seen = 0;
    accepted = 0;
    in_flight = 1'b0;
    ready_random = 1'b0;
    rst = 1'b1;
    req_valid = 1'b0;
    req_op = DMA_OP_NOP;
    req_laddr = '0;
    req_size = '0;
    req_dest = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    // Short transfers with an always ready NoC
    send_request(DMA_OP_L2R, 32'h0000_1000, 10'd1, 5'd3);
    wait_done();
    send_request(DMA_OP_L2R, 32'h0000_2040, 10'd3, 5'd17);
    wait_done();
    // Longer ones under back-pressure
    ready_random = 1'b1;
    send_request(DMA_OP_L2R, 32'h0001_0000, 10'd17, 5'd30);
    wait_done();
    send_request(DMA_OP_L2R, 32'h00ab_cd00, 10'd64, 5'd9);
    wait_done();
    refuse_idle(DMA_OP_R2L, 10'd4);
    refuse_idle(DMA_OP_NOP, 10'd4);
    refuse_idle(DMA_OP_L2R, 10'd0);
    // Second strobe lands mid-transfer
    send_request(DMA_OP_L2R, 32'h0000_0300, 10'd17, 5'd1);
    repeat (3) @(negedge clk);
    send_request(DMA_OP_L2R, 32'h0000_0900, 10'd4, 5'd2);
    wait_done();
    finish_run();
  end

endmodule

`default_nettype wire

/* list.f */
logic/dma_pkg.sv
logic/dma_req_decoder.sv
logic/dma_wb_fetch.sv
logic/dma_noc_packetizer.sv
logic/dma_initiator_top.sv
tests/wb_mem_model.sv
tests/dma_initiator_asserts.sv
tests/tb_dma_initiator.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_dma_initiator
FILELIST   := list.f
LOG        := sim.log
FAIL_MSG   := Test failures found
BIN        := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
